//--- audio_in_defines.svh
`ifndef AUDIO_IN_DEFINES_SVH
`define AUDIO_IN_DEFINES_SVH

// bits kept from each slot, msb first
`define AUDIO_SAMPLE_W 24

// sclk cycles in one lrck half period
`define AUDIO_SLOT_CLKS 32

// averaging block is 2**AUDIO_AVG_LOG2 samples
`define AUDIO_AVG_LOG2 2

// wishbone word address bits
`define AUDIO_WB_ADR_W 3

`endif

//--- audio_in_pkg.sv
`include "audio_in_defines.svh"

package audio_in_pkg;

   typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;   // two's complement slot data

   // abs of the most negative sample is 2**23, so no sign bit here
   typedef logic [`AUDIO_SAMPLE_W-1:0] avg_t;

   typedef logic [`AUDIO_WB_ADR_W-1:0] wb_adr_t;

   typedef enum logic [1:0] {
      rx_idle,    // waiting for own lrck edge
      rx_shift,   // taking bits msb first
      rx_store    // hand the word out
   } rx_state_t;

   typedef enum wb_adr_t {
      reg_left_sample  = 0,
      reg_right_sample = 1,
      reg_left_avg     = 2,
      reg_right_avg    = 3,
      reg_frame_count  = 4
   } reg_addr_t;

   // which lrck edge opens the slot
   typedef enum logic {chan_left, chan_right} chan_sel_t;

endpackage

//--- audio_chan_if.sv
`timescale 1ns/1ps

interface audio_chan_if;
   import audio_in_pkg::*;

   sample_t sample;        // last captured slot
   logic    sample_valid;  // one cycle, no back-pressure
   avg_t    avg;           // block mean of |sample|
   logic    avg_valid;     // one cycle per finished block

   modport rx (
      output sample,
      output sample_valid,
      output avg,
      output avg_valid
   );

   modport sink (
      input sample,
      input sample_valid,
      input avg,
      input avg_valid
   );

endinterface

//--- i2s_channel_rx.sv
`timescale 1ns/1ps
`include "audio_in_defines.svh"

module i2s_channel_rx #(
   parameter audio_in_pkg::chan_sel_t chan = audio_in_pkg::chan_left
) (
   input  logic     IIS_SCLK_I,
   input  logic     rst_in,
   input  logic     enable,
   input  logic     lrck,
   input  logic     sdin,
   audio_chan_if.rx chan_out
);
   import audio_in_pkg::*;

   localparam int CNT_W = $clog2(`AUDIO_SLOT_CLKS);   // bit counter spans one slot
   localparam int SUM_W = `AUDIO_SAMPLE_W + `AUDIO_AVG_LOG2;
   localparam int BLK_W = `AUDIO_AVG_LOG2 + 1;
   localparam int BLK_N = 1 << `AUDIO_AVG_LOG2;

   rx_state_t                  state;
   logic                       lrck_prev;
   logic                       slot_start;
   logic [CNT_W-1:0]           bit_cnt;
   logic [`AUDIO_SAMPLE_W-1:0] shreg;
   avg_t                       sample_abs;
   logic [SUM_W-1:0]           acc;
   logic [SUM_W-1:0]           acc_next;
   logic [BLK_W-1:0]           blk_cnt;
   logic                       block_done;

   //////////////////////////////
   // lrck edge, own copy per channel

   always_ff @(posedge IIS_SCLK_I) begin
      if (rst_in) begin
         lrck_prev <= (chan == chan_right);   // no false edge out of reset
      end else begin
         lrck_prev <= lrck;
      end
   end

   // left opens on high->low, right on low->high
   assign slot_start = (chan == chan_left) ? (lrck_prev & ~lrck) : (~lrck_prev & lrck);

   //////////////////////////////
   // slot capture

   always_ff @(posedge IIS_SCLK_I) begin
      if (rst_in || !enable) begin
         state                 <= rx_idle;
         bit_cnt               <= '0;
         chan_out.sample_valid <= 1'b0;
      end else begin
         chan_out.sample_valid <= 1'b0;
         case (state)
            rx_idle: begin
               if (slot_start) begin
                  state   <= rx_shift;
                  bit_cnt <= CNT_W'(`AUDIO_SAMPLE_W);
               end
            end
            rx_shift: begin
               bit_cnt <= bit_cnt - 1'b1;
               if (bit_cnt == CNT_W'(1)) begin
                  state <= rx_store;   // rest of the slot is ignored
               end
            end
            rx_store: begin
               chan_out.sample_valid <= 1'b1;
               state                 <= rx_idle;
            end
            default: state <= rx_idle;
         endcase
      end
   end

   always_ff @(posedge IIS_SCLK_I) begin
      if (state == rx_shift) begin
         shreg <= {shreg[`AUDIO_SAMPLE_W-2:0], sdin};
      end
      if (enable && state == rx_store) begin
         chan_out.sample <= shreg;
      end
   end

   //////////////////////////////
   // block average of |sample|

   assign sample_abs = chan_out.sample[`AUDIO_SAMPLE_W-1] ? avg_t'(-chan_out.sample)
                                                          : avg_t'(chan_out.sample);
   assign acc_next   = acc + SUM_W'(sample_abs);
   assign block_done = enable && chan_out.sample_valid && (blk_cnt == BLK_W'(BLK_N - 1));

   always_ff @(posedge IIS_SCLK_I) begin
      if (rst_in || !enable) begin
         acc                <= '0;
         blk_cnt            <= '0;
         chan_out.avg_valid <= 1'b0;
      end else begin
         chan_out.avg_valid <= block_done;
         if (block_done) begin
            acc     <= '0;
            blk_cnt <= '0;
         end else if (chan_out.sample_valid) begin
            acc     <= acc_next;
            blk_cnt <= blk_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge IIS_SCLK_I) begin
      if (block_done) begin
         chan_out.avg <= avg_t'(acc_next >> `AUDIO_AVG_LOG2);   // floor of the mean
      end
   end

   // store state is left after one cycle
   a_single_strobe: assert property (@(posedge IIS_SCLK_I) disable iff (rst_in)
      chan_out.sample_valid |=> !chan_out.sample_valid);

endmodule

//--- audio_wb_regs.sv
`timescale 1ns/1ps

module audio_wb_regs (
   input  logic                  IIS_SCLK_I,
   input  logic                  rst_in,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  audio_in_pkg::wb_adr_t wb_adr,
   input  logic [31:0]           wb_dat_wr,
   audio_chan_if.sink            left,
   audio_chan_if.sink            right,
   output logic [31:0]           wb_dat_rd,
   output logic                  wb_ack
);
   import audio_in_pkg::*;

   logic        left_pending;   // left seen, right not yet
   sample_t     left_hold;
   sample_t     frame_left;
   sample_t     frame_right;
   logic [15:0] frame_count;
   avg_t        left_avg;
   avg_t        right_avg;
   logic        wb_req;
   logic [31:0] rd_data;

   //////////////////////////////
   // frame pairing

   always_ff @(posedge IIS_SCLK_I) begin
      if (left.sample_valid) begin
         left_hold <= left.sample;
      end
   end

   always_ff @(posedge IIS_SCLK_I) begin
      if (rst_in) begin
         left_pending <= 1'b0;
         frame_left   <= '0;
         frame_right  <= '0;
         frame_count  <= '0;
      end else begin
         if (right.sample_valid && left_pending) begin
            frame_left   <= left_hold;        // both halves land together
            frame_right  <= right.sample;
            frame_count  <= frame_count + 1'b1;
            left_pending <= 1'b0;
         end
         if (left.sample_valid) begin
            left_pending <= 1'b1;
         end
      end
   end

   always_ff @(posedge IIS_SCLK_I) begin
      if (rst_in) begin
         left_avg  <= '0;
         right_avg <= '0;
      end else begin
         if (left.avg_valid)  left_avg  <= left.avg;
         if (right.avg_valid) right_avg <= right.avg;
      end
   end

   //////////////////////////////
   // wishbone classic slave

   assign wb_req = wb_cyc & wb_stb & ~wb_ack;   // master still holds stb in ack cycle

   always_comb begin
      case (reg_addr_t'(wb_adr))
         reg_left_sample:  rd_data = 32'(frame_left);   // sign extends
         reg_right_sample: rd_data = 32'(frame_right);
         reg_left_avg:     rd_data = 32'(left_avg);
         reg_right_avg:    rd_data = 32'(right_avg);
         reg_frame_count:  rd_data = 32'(frame_count);
         default:          rd_data = '0;                // unmapped
      endcase
   end

   always_ff @(posedge IIS_SCLK_I) begin
      if (rst_in) begin
         wb_ack    <= 1'b0;
         wb_dat_rd <= '0;
      end else begin
         wb_ack <= wb_req;
         if (wb_req) begin
            wb_dat_rd <= wb_we ? '0 : rd_data;   // writes have no target
         end
      end
   end

   a_ack_after_req: assert property (@(posedge IIS_SCLK_I) disable iff (rst_in)
      wb_ack |-> $past(wb_cyc && wb_stb));

   // master side check on write cycles
   a_wr_data_known: assert property (@(posedge IIS_SCLK_I) disable iff (rst_in)
      (wb_cyc && wb_stb && wb_we) |-> !$isunknown(wb_dat_wr));

endmodule

//--- audio_in_top.sv
`timescale 1ns/1ps

module audio_in_top (
   input  logic                  IIS_SCLK_I,
   input  logic                  rst_in,
   input  logic                  enable,
   input  logic                  lrck,
   input  logic                  sdin,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  audio_in_pkg::wb_adr_t wb_adr,
   input  logic [31:0]           wb_dat_wr,
   output logic [31:0]           wb_dat_rd,
   output logic                  wb_ack
);
   import audio_in_pkg::*;

   //////////////////////////////
   // per channel results

   audio_chan_if left_if();
   audio_chan_if right_if();

   // both receivers watch the same lrck and sdin
   i2s_channel_rx #(
      .chan (chan_left)
   ) left_rx_inst (
      .IIS_SCLK_I (IIS_SCLK_I),
      .rst_in     (rst_in),
      .enable     (enable),
      .lrck       (lrck),
      .sdin       (sdin),
      .chan_out   (left_if)
   );

   i2s_channel_rx #(
      .chan (chan_right)
   ) right_rx_inst (
      .IIS_SCLK_I (IIS_SCLK_I),
      .rst_in     (rst_in),
      .enable     (enable),
      .lrck       (lrck),
      .sdin       (sdin),
      .chan_out   (right_if)
   );

   //////////////////////////////
   // host side

   audio_wb_regs regs_inst (
      .IIS_SCLK_I (IIS_SCLK_I),
      .rst_in     (rst_in),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_wr  (wb_dat_wr),
      .left       (left_if),     // pairs left then right
      .right      (right_if),
      .wb_dat_rd  (wb_dat_rd),
      .wb_ack     (wb_ack)
   );

endmodule

//--- tb_audio_in.sv
`timescale 1ns/1ps
`include "audio_in_defines.svh"

module tb_audio_in;
   import audio_in_pkg::*;

   localparam int RESET_CYCLES    = 10;
   localparam int ROWS            = 16;
   localparam int FRAMES          = ROWS + 2;         // table plus the enable test
   localparam int MAX_READS       = ROWS * 5 + 40;
   localparam int WATCHDOG_CYCLES = 2 * (FRAMES * 64 + MAX_READS * 40) + RESET_CYCLES;
   localparam int BLK_N           = 1 << `AUDIO_AVG_LOG2;
   localparam int SW              = `AUDIO_SAMPLE_W;

   logic        IIS_SCLK_I;
   logic        rst_in;
   logic        enable;
   logic        lrck;
   logic        sdin;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   wb_adr_t     wb_adr;
   logic [31:0] wb_dat_wr;
   logic [31:0] wb_dat_rd;
   logic        wb_ack;

   sample_t     left_tab [ROWS];
   sample_t     right_tab [ROWS];
   logic        read_tab [ROWS];
   logic [31:0] lcg_state;
   logic [31:0] rd;

   // reference model state
   logic [15:0] frames_sent;
   longint      sum_left;
   longint      sum_right;
   int          blk_cnt;
   logic        block_done;
   avg_t        exp_left_avg;
   avg_t        exp_right_avg;
   sample_t     last_left;
   sample_t     last_right;

   audio_in_top audio_in_top_inst (.*);

   always #10 IIS_SCLK_I = ~IIS_SCLK_I;

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge IIS_SCLK_I);
      report_failure($sformatf("timeout: run did not finish within %0d clock cycles",
                               WATCHDOG_CYCLES));
   end

   //////////////////////////////
   // helpers

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic longint abs_value(input sample_t s);
      longint v;
      v = s;   // sign extends
      return (v < 0) ? -v : v;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_sample(input string what, input sample_t exp, input logic [31:0] obs);
      logic [31:0] want;
      want = {{(32-SW){exp[SW-1]}}, exp};
      if (obs !== want)
         report_failure($sformatf("** Error @ %0t ns: %s expected %h observed %h",
                                  $time, what, want, obs));
   endtask

   task automatic check_avg(input string what, input avg_t exp, input logic [31:0] obs);
      if (obs !== {{(32-SW){1'b0}}, exp})
         report_failure($sformatf("** Error @ %0t ns: %s expected %h observed %h",
                                  $time, what, exp, obs));
   endtask

   task automatic check_count(input logic [15:0] exp, input logic [31:0] obs);
      if (obs !== {16'h0000, exp})
         report_failure($sformatf("** Error @ %0t ns: frame count expected %0d observed %0d",
                                  $time, exp, obs));
   endtask

   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] obs);
      if (obs !== exp)
         report_failure($sformatf("** Error @ %0t ns: %s expected %h observed %h",
                                  $time, what, exp, obs));
   endtask

   //////////////////////////////
   // wishbone master

   task automatic wb_access(input logic we, input wb_adr_t adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(posedge IIS_SCLK_I);
      #1;
      wb_cyc    = 1'b1;
      wb_stb    = 1'b1;
      wb_we     = we;
      wb_adr    = adr;
      wb_dat_wr = wdata;
      do begin
         @(posedge IIS_SCLK_I);
         #1;
         waited++;
         if (!wb_ack && waited > 16)
            report_failure($sformatf("wishbone access to address %0d was never acknowledged", adr));
      end while (!wb_ack);
      rdata  = wb_dat_rd;   // valid in the ack cycle
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_reg(input wb_adr_t adr, output logic [31:0] rdata);
      wb_access(1'b0, adr, 32'h0, rdata);
   endtask

   //////////////////////////////
   // i2s source sends left slot then right slot

   task automatic send_frame(input sample_t l, input sample_t r, input int drop_at);
      sample_t word;
      for (int half = 0; half < 2; half++) begin
         word = (half == 0) ? l : r;
         for (int j = 0; j < `AUDIO_SLOT_CLKS; j++) begin
            @(posedge IIS_SCLK_I);
            #1;
            lrck = half[0];
            sdin = (j >= 1 && j <= SW) ? word[SW-j] : 1'b0;   // msb one bit after lrck
            if (half == 0 && j == drop_at) enable = 1'b0;
         end
      end
   endtask

   task automatic model_frame(input sample_t l, input sample_t r);
      frames_sent++;
      sum_left   += abs_value(l);
      sum_right  += abs_value(r);
      last_left  = l;
      last_right = r;
      blk_cnt++;
      block_done = 1'b0;
      if (blk_cnt == BLK_N) begin
         exp_left_avg  = avg_t'(sum_left / BLK_N);   // floor of the mean
         exp_right_avg = avg_t'(sum_right / BLK_N);
         sum_left      = 0;
         sum_right     = 0;
         blk_cnt       = 0;
         block_done    = 1'b1;
      end
   endtask

   task automatic check_frame();
      read_reg(wb_adr_t'(reg_left_sample), rd);
      check_sample("left sample", last_left, rd);
      read_reg(wb_adr_t'(reg_right_sample), rd);
      check_sample("right sample", last_right, rd);
      read_reg(wb_adr_t'(reg_frame_count), rd);
      check_count(frames_sent, rd);
   endtask

   task automatic check_avgs();
      read_reg(wb_adr_t'(reg_left_avg), rd);
      check_avg("left average", exp_left_avg, rd);
      read_reg(wb_adr_t'(reg_right_avg), rd);
      check_avg("right average", exp_right_avg, rd);
   endtask

   //////////////////////////////
   // main sequence

   initial begin
      IIS_SCLK_I = 1'b0;
      rst_in     = 1'b1;
      enable     = 1'b1;
      lrck       = 1'b1;   // idle high so the first low opens a left slot
      sdin       = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_wr  = '0;
      frames_sent   = '0;
      sum_left      = 0;
      sum_right     = 0;
      blk_cnt       = 0;
      block_done    = 1'b0;
      exp_left_avg  = '0;
      exp_right_avg = '0;
      last_left     = '0;
      last_right    = '0;

      // fixed corner rows
      left_tab[0]  = 24'sh000000;
      right_tab[0] = 24'sh000000;
      left_tab[1]  = 24'sh7fffff;
      right_tab[1] = 24'sh7fffff;
      left_tab[2]  = 24'sh800001;
      right_tab[2] = 24'sh800001;
      left_tab[3]  = 24'shffffff;
      right_tab[3] = 24'sh000001;
      left_tab[4]  = 24'sh800000;   // abs is 2**23
      right_tab[4] = 24'sh800000;
      left_tab[5]  = 24'sh123456;
      right_tab[5] = 24'shedcbaa;
      left_tab[6]  = 24'sh000001;
      right_tab[6] = 24'shfffffe;
      left_tab[7]  = 24'sh400000;
      right_tab[7] = 24'shc00000;
      for (int i = 0; i < 8; i++) read_tab[i] = 1'b1;

      lcg_state = 32'h6b966dd8;
      for (int i = 8; i < ROWS; i++) begin
         lcg_state    = lcg_next(lcg_state);
         left_tab[i]  = lcg_state[31:8];
         lcg_state    = lcg_next(lcg_state);
         right_tab[i] = lcg_state[31:8];
         read_tab[i]  = lcg_state[7] | (i == ROWS - 1);
      end

      repeat (RESET_CYCLES) @(posedge IIS_SCLK_I);
      #1;
      rst_in = 1'b0;

      // everything reads zero out of reset
      for (int a = 0; a < 8; a++) begin
         read_reg(wb_adr_t'(a), rd);
         check_word($sformatf("register %0d after reset", a), 32'h0, rd);
      end

      for (int i = 0; i < ROWS; i++) begin
         send_frame(left_tab[i], right_tab[i], -1);
         model_frame(left_tab[i], right_tab[i]);
         if (read_tab[i]) check_frame();
         if (block_done) check_avgs();
      end

      // writes are acked and change nothing
      for (int a = 0; a < 8; a++) wb_access(1'b1, wb_adr_t'(a), 32'hffff_fff0 | a, rd);
      check_frame();
      check_avgs();
      for (int a = 5; a < 8; a++) begin
         read_reg(wb_adr_t'(a), rd);
         check_word($sformatf("unmapped register %0d", a), 32'h0, rd);
      end

      // enable drop inside a left slot
      send_frame(24'sh555555, 24'sh2aaaaa, 12);
      sum_left  = 0;
      sum_right = 0;
      blk_cnt   = 0;
      repeat (4) @(posedge IIS_SCLK_I);
      #1;
      enable = 1'b1;
      lcg_state = lcg_next(lcg_state);
      send_frame(lcg_state[31:8], ~lcg_state[23:0], -1);
      model_frame(lcg_state[31:8], ~lcg_state[23:0]);
      check_frame();
      check_avgs();   // averages hold while the block is not full

      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- audio_in.f
+incdir+.
audio_in_pkg.sv
audio_chan_if.sv
i2s_channel_rx.sv
audio_wb_regs.sv
audio_in_top.sv
tb_audio_in.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio_in testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f audio_in.f \
   --top-module tb_audio_in -o sim_audio_in > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_audio_in > sim.log 2>&1
cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1
